//--- project.f
+incdir+test
verilog/scaler_pkg.sv
verilog/scale_setup.sv
verilog/raster_fsm.sv
verilog/neighbor_fetch.sv
verilog/bilinear_blend.sv
verilog/bilinear_scaler_top.sv
test/tb_bilinear_scaler.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the bilinear scaler testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f project.f \
  --top-module tb_bilinear_scaler -o tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi

if grep -q "Simulation completed successfully" "$LOG"; then
  exit 0
fi
exit 1

//--- test/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Output size is the floor of size * scale / 256
function automatic dim_t out_dim_rule(input dim_t size, input q88_t scale);
  int prod;
  prod = int'(size) * int'(scale);
  return dim_t'(prod >> 8);
endfunction

// Inverse scale in Q8.8, floor of 65536 / scale
function automatic int inverse_scale(input q88_t scale);
  return 65536 / int'(scale);
endfunction

// One output pixel from the source image in src_mem
function automatic int expected_pixel(input int ox, input int oy, input int in_w,
                                      input int in_h, input int inv);
  int sx;
  int sy;
  int x0;
  int y0;
  int fx;
  int fy;
  int acc;
  // Q16.8 source position
  sx = ox * inv;
  sy = oy * inv;
  x0 = sx >> 8;
  y0 = sy >> 8;
  fx = sx & 255;
  fy = sy & 255;
  // Edge clamp keeps the right or bottom neighbour inside the image
  if (x0 >= in_w - 1) begin
    x0 = in_w - 2;
    fx = 255;
  end
  if (y0 >= in_h - 1) begin
    y0 = in_h - 2;
    fy = 255;
  end
  // Q0.16 weights times pixels, then round at bit 15
  acc = (256 - fx) * (256 - fy) * int'(src_mem[y0 * in_w + x0]);
  acc = acc + fx * (256 - fy) * int'(src_mem[y0 * in_w + x0 + 1]);
  acc = acc + (256 - fx) * fy * int'(src_mem[(y0 + 1) * in_w + x0]);
  acc = acc + fx * fy * int'(src_mem[(y0 + 1) * in_w + x0 + 1]);
  acc = acc + 32'h8000;
  return (acc >> 16) & 255;
endfunction

`endif

//--- test/tb_bilinear_scaler.sv
`timescale 1ns/1ps

module tb_bilinear_scaler;

  import scaler_pkg::*;

  localparam int AW        = 12;
  localparam int MEM_DEPTH = 1 << AW;
  localparam int NCASES    = 6;
  localparam logic [31:0] SEED = 32'h6d143ff5;

  // One row of the case table
  typedef struct packed {
    dim_t in_w;
    dim_t in_h;
    q88_t scale;
    logic ramp;
    dim_t exp_w;
    dim_t exp_h;
  } case_t;

  logic          clk;
  logic          rst_n;
  logic          i_start;
  dim_t          i_in_w;
  dim_t          i_in_h;
  q88_t          i_scale_q88;
  pixel_t        src_rdata = 8'h00;
  logic          o_busy;
  logic          o_done;
  dim_t          o_out_w;
  dim_t          o_out_h;
  logic [AW-1:0] o_src_raddr;
  logic [AW-1:0] o_dst_waddr;
  pixel_t        o_dst_wdata;
  logic          o_dst_we;

  case_t  cases [NCASES];
  pixel_t src_mem [MEM_DEPTH];
  pixel_t dst_mem [MEM_DEPTH];
  int     wr_count [MEM_DEPTH];
  int     write_total;
  int     done_count;
  logic   clr_req;
  int     err_count = 0;

  `include "tb_ref_model.svh"

  bilinear_scaler_top #(
    .AW (AW)
  ) u_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_start     (i_start),
    .i_in_w      (i_in_w),
    .i_in_h      (i_in_h),
    .i_scale_q88 (i_scale_q88),
    .i_src_rdata (src_rdata),
    .o_busy      (o_busy),
    .o_done      (o_done),
    .o_out_w     (o_out_w),
    .o_out_h     (o_out_h),
    .o_src_raddr (o_src_raddr),
    .o_dst_waddr (o_dst_waddr),
    .o_dst_wdata (o_dst_wdata),
    .o_dst_we    (o_dst_we)
  );

  // 4 ns clock
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Source RAM with one cycle of read latency
  always @(posedge clk) begin
    src_rdata <= src_mem[o_src_raddr];
  end

  // ------------------------------
  // Destination capture
  // ------------------------------
  always @(negedge clk) begin
    if (clr_req) begin
      for (int a = 0; a < MEM_DEPTH; a++) begin
        dst_mem[a]  <= 8'h00;
        wr_count[a] <= 0;
      end
      write_total <= 0;
      done_count  <= 0;
    end else begin
      if (o_dst_we) begin
        dst_mem[o_dst_waddr]  <= o_dst_wdata;
        wr_count[o_dst_waddr] <= wr_count[o_dst_waddr] + 1;
        write_total           <= write_total + 1;
      end
      if (o_done) begin
        done_count <= done_count + 1;
      end
    end
  end

  task automatic check_dim(input string name, input dim_t got, input dim_t exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%04h expected 0x%04h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_pix(input string name, input pixel_t got, input pixel_t exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%02h expected 0x%02h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%01h expected 0x%01h", name, got, exp);
      err_count++;
    end
  endtask

  // Ramp mixes the upper address bits in
  task automatic fill_source(input logic ramp);
    for (int a = 0; a < MEM_DEPTH; a++) begin
      if (ramp) begin
        src_mem[a] = pixel_t'(a * 3 + (a >> 6));
      end else begin
        src_mem[a] = pixel_t'($urandom);
      end
    end
  endtask

  // ------------------------------
  // Watchdog
  // ------------------------------
  initial begin : watchdog
    int budget;
    @(posedge rst_n);
    budget = 0;
    for (int i = 0; i < NCASES; i++) begin
      budget += 10 * int'(cases[i].exp_w) * int'(cases[i].exp_h) + 100;
    end
    repeat (budget) @(posedge clk);
    $display("watchdog expired after %0d cycles, run did not finish", budget);
    $display("Simulation failed");
    $finish;
  end

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin : main_seq
    int w_in;
    int h_in;
    int w_out;
    int h_out;
    int inv;
    int addr;
    int waited;
    int limit;
    int errs_before;
    int passed;
    int failed;
    void'($urandom(SEED));
    passed      = 0;
    failed      = 0;
    rst_n       = 1'b0;
    i_start     = 1'b0;
    i_in_w      = '0;
    i_in_h      = '0;
    i_scale_q88 = '0;
    clr_req     = 1'b0;

    // in_w, in_h, scale, ramp, expected out_w, out_h
    cases[0] = '{16'd8,  16'd6,  16'h0100, 1'b1, 16'd8,  16'd6};
    cases[1] = '{16'd7,  16'd5,  16'h0200, 1'b0, 16'd14, 16'd10};
    cases[2] = '{16'd9,  16'd7,  16'h0180, 1'b0, 16'd13, 16'd10};
    cases[3] = '{16'd16, 16'd12, 16'h0080, 1'b0, 16'd8,  16'd6};
    cases[4] = '{16'd6,  16'd4,  16'h0180, 1'b1, 16'd9,  16'd6};
    cases[5] = '{16'd10, 16'd8,  16'h0100, 1'b0, 16'd10, 16'd8};

    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_flag("o_busy", o_busy, 1'b0);
    check_flag("o_done", o_done, 1'b0);
    check_flag("o_dst_we", o_dst_we, 1'b0);

    for (int ci = 0; ci < NCASES; ci++) begin
      errs_before = err_count;
      w_in  = int'(cases[ci].in_w);
      h_in  = int'(cases[ci].in_h);
      w_out = int'(cases[ci].exp_w);
      h_out = int'(cases[ci].exp_h);
      inv   = inverse_scale(cases[ci].scale);
      if (out_dim_rule(cases[ci].in_w, cases[ci].scale) !== cases[ci].exp_w ||
          out_dim_rule(cases[ci].in_h, cases[ci].scale) !== cases[ci].exp_h) begin
        $display("case %0d table row disagrees with the size rule", ci);
        err_count++;
      end
      fill_source(cases[ci].ramp);

      @(posedge clk);
      clr_req     <= 1'b1;
      i_in_w      <= cases[ci].in_w;
      i_in_h      <= cases[ci].in_h;
      i_scale_q88 <= cases[ci].scale;
      @(posedge clk);
      clr_req <= 1'b0;
      i_start <= 1'b1;
      @(posedge clk);
      i_start <= 1'b0;
      @(negedge clk);
      check_flag("o_busy", o_busy, 1'b1);
      check_dim("o_out_w", o_out_w, cases[ci].exp_w);
      check_dim("o_out_h", o_out_h, cases[ci].exp_h);

      // Wait for the end of the frame
      waited = 0;
      limit  = 10 * w_out * h_out + 100;
      while (o_done !== 1'b1 && waited < limit) begin
        @(negedge clk);
        waited++;
      end
      if (o_done !== 1'b1) begin
        $display("case %0d: done never arrived within %0d cycles", ci, limit);
        err_count++;
      end else begin
        check_flag("o_busy at done", o_busy, 1'b0);
      end
      repeat (3) @(negedge clk);
      if (done_count != 1) begin
        $display("case %0d: done pulsed %0d times instead of once", ci, done_count);
        err_count++;
      end
      if (write_total != w_out * h_out) begin
        $display("case %0d: %0d writes seen, %0d expected", ci, write_total,
                 w_out * h_out);
        err_count++;
      end

      // Every address once, every value from the model
      for (int oy = 0; oy < h_out; oy++) begin
        for (int ox = 0; ox < w_out; ox++) begin
          addr = oy * w_out + ox;
          if (wr_count[addr] == 0) begin
            $display("case %0d: address %0d never written", ci, addr);
            err_count++;
          end else if (wr_count[addr] > 1) begin
            $display("case %0d: address %0d written %0d times", ci, addr, wr_count[addr]);
            err_count++;
          end
          check_pix($sformatf("o_dst_wdata[%0d]", addr), dst_mem[addr],
                    pixel_t'(expected_pixel(ox, oy, w_in, h_in, inv)));
          // Identity scale copies interior pixels untouched
          if (cases[ci].scale == 16'h0100 && ox < w_in - 1 && oy < h_in - 1) begin
            check_pix($sformatf("identity o_dst_wdata[%0d]", addr), dst_mem[addr],
                      src_mem[oy * w_in + ox]);
          end
        end
      end

      if (err_count == errs_before) begin
        passed++;
        $display("case %0d: %0dx%0d scale 0x%04h -> %0dx%0d ok", ci, w_in, h_in,
                 cases[ci].scale, w_out, h_out);
      end else begin
        failed++;
        $display("case %0d: %0dx%0d scale 0x%04h -> %0dx%0d FAILED with %0d errors", ci,
                 w_in, h_in, cases[ci].scale, w_out, h_out, err_count - errs_before);
      end
    end

    $display("cases run %0d, passed %0d, failed %0d, errors %0d", NCASES, passed, failed,
             err_count);
    if (err_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- verilog/bilinear_blend.sv
`timescale 1ns/1ps

module bilinear_blend (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   i_quad_valid,
  input  scaler_pkg::quad_pix_t  i_quad,
  input  scaler_pkg::src_point_t i_pt,
  output scaler_pkg::pixel_t     o_pix,
  output logic                   o_pix_valid
);

  import scaler_pkg::*;

  // 1D weights in Q0.8 with room for 1.0
  logic [8:0]  wx0;
  logic [8:0]  wx1;
  logic [8:0]  wy0;
  logic [8:0]  wy1;
  // 2D weights in Q0.16
  logic [17:0] w00;
  logic [17:0] w10;
  logic [17:0] w01;
  logic [17:0] w11;
  // Registered Q8.16 terms
  logic [31:0] prod00_r;
  logic [31:0] prod10_r;
  logic [31:0] prod01_r;
  logic [31:0] prod11_r;
  logic        prod_valid;
  logic [31:0] sum_q016;

  assign wx1 = {1'b0, i_pt.fx};
  assign wx0 = ONE_Q08 - wx1;
  assign wy1 = {1'b0, i_pt.fy};
  assign wy0 = ONE_Q08 - wy1;

  assign w00 = wx0 * wy0;
  assign w10 = wx1 * wy0;
  assign w01 = wx0 * wy1;
  assign w11 = wx1 * wy1;

  // ------------------------------
  // Stage 1 products
  // ------------------------------
  always_ff @(posedge clk) begin
    if (i_quad_valid) begin
      prod00_r <= 32'(w00) * 32'(i_quad.p00);
      prod10_r <= 32'(w10) * 32'(i_quad.p10);
      prod01_r <= 32'(w01) * 32'(i_quad.p01);
      prod11_r <= 32'(w11) * 32'(i_quad.p11);
    end
  end

  // Round to nearest before dropping 16 fraction bits
  assign sum_q016 = prod00_r + prod10_r + prod01_r + prod11_r + ROUND_Q016;

  // Stage 2 result
  always_ff @(posedge clk) begin
    if (prod_valid) begin
      o_pix <= sum_q016[23:16];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prod_valid  <= 1'b0;
      o_pix_valid <= 1'b0;
    end else begin
      prod_valid  <= i_quad_valid;
      o_pix_valid <= prod_valid;
    end
  end

endmodule

//--- verilog/bilinear_scaler_top.sv
`timescale 1ns/1ps

module bilinear_scaler_top #(
  parameter int AW = 19
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               i_start,
  input  scaler_pkg::dim_t   i_in_w,
  input  scaler_pkg::dim_t   i_in_h,
  input  scaler_pkg::q88_t   i_scale_q88,
  input  scaler_pkg::pixel_t i_src_rdata,
  output logic               o_busy,
  output logic               o_done,
  output scaler_pkg::dim_t   o_out_w,
  output scaler_pkg::dim_t   o_out_h,
  output logic [AW-1:0]      o_src_raddr,
  output logic [AW-1:0]      o_dst_waddr,
  output scaler_pkg::pixel_t o_dst_wdata,
  output logic               o_dst_we
);

  import scaler_pkg::*;

  // Start only counts while idle
  logic       start_ok;
  scale_cfg_t cfg;
  logic       fetch_start;
  dim_t       ox;
  dim_t       oy;
  src_point_t pt;
  quad_pix_t  quad;
  logic       quad_valid;
  pixel_t     pix;
  logic       pix_valid;

  assign start_ok = i_start & ~o_busy;

  // Sizes stay valid after done
  assign o_out_w  = cfg.out_w;
  assign o_out_h  = cfg.out_h;

  // ------------------------------
  // Datapath blocks
  // ------------------------------
  scale_setup u_setup (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_start     (start_ok),
    .i_in_w      (i_in_w),
    .i_in_h      (i_in_h),
    .i_scale_q88 (i_scale_q88),
    .o_cfg       (cfg)
  );

  raster_fsm #(
    .AW (AW)
  ) u_fsm (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_start       (start_ok),
    .i_cfg         (cfg),
    .i_pix_valid   (pix_valid),
    .i_pix         (pix),
    .o_busy        (o_busy),
    .o_done        (o_done),
    .o_fetch_start (fetch_start),
    .o_ox          (ox),
    .o_oy          (oy),
    .o_dst_waddr   (o_dst_waddr),
    .o_dst_wdata   (o_dst_wdata),
    .o_dst_we      (o_dst_we)
  );

  neighbor_fetch #(
    .AW (AW)
  ) u_fetch (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_fetch_start (fetch_start),
    .i_cfg         (cfg),
    .i_ox          (ox),
    .i_oy          (oy),
    .i_src_rdata   (i_src_rdata),
    .o_src_raddr   (o_src_raddr),
    .o_pt          (pt),
    .o_quad        (quad),
    .o_quad_valid  (quad_valid)
  );

  bilinear_blend u_blend (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_quad_valid (quad_valid),
    .i_quad       (quad),
    .i_pt         (pt),
    .o_pix        (pix),
    .o_pix_valid  (pix_valid)
  );

endmodule

//--- verilog/neighbor_fetch.sv
`timescale 1ns/1ps

module neighbor_fetch #(
  parameter int AW = 19
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   i_fetch_start,
  input  scaler_pkg::scale_cfg_t i_cfg,
  input  scaler_pkg::dim_t       i_ox,
  input  scaler_pkg::dim_t       i_oy,
  input  scaler_pkg::pixel_t     i_src_rdata,
  output logic [AW-1:0]          o_src_raddr,
  output scaler_pkg::src_point_t o_pt,
  output scaler_pkg::quad_pix_t  o_quad,
  output logic                   o_quad_valid
);

  import scaler_pkg::*;

  // Source coordinates in Q16.8
  logic [31:0] sx_fix;
  logic [31:0] sy_fix;
  dim_t        sx_int;
  dim_t        sy_int;
  src_point_t  pt_next;
  logic [31:0] base_lin;
  // Read sequence step, 0 when idle
  logic [2:0]  cnt;

  assign sx_fix = 32'(i_ox) * 32'(i_cfg.inv_scale);
  assign sy_fix = 32'(i_oy) * 32'(i_cfg.inv_scale);
  assign sx_int = sx_fix[23:8];
  assign sy_int = sy_fix[23:8];

  // ------------------------------
  // Edge clamping
  // ------------------------------
  always_comb begin
    pt_next.x0 = sx_int;
    pt_next.fx = sx_fix[7:0];
    pt_next.y0 = sy_int;
    pt_next.fy = sy_fix[7:0];
    // Last column keeps the pair inside the image
    if (sx_int >= i_cfg.in_w - 16'd1) begin
      pt_next.x0 = i_cfg.in_w - 16'd2;
      pt_next.fx = 8'hFF;
    end
    if (sy_int >= i_cfg.in_h - 16'd1) begin
      pt_next.y0 = i_cfg.in_h - 16'd2;
      pt_next.fy = 8'hFF;
    end
  end

  // Address of p00
  assign base_lin = 32'(pt_next.y0) * 32'(i_cfg.in_w) + 32'(pt_next.x0);

  // ------------------------------
  // Read sequencer
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt          <= 3'd0;
      o_quad_valid <= 1'b0;
      o_src_raddr  <= '0;
    end else begin
      o_quad_valid <= 1'b0;
      if (i_fetch_start) begin
        cnt         <= 3'd1;
        o_src_raddr <= base_lin[AW-1:0];
      end else if (cnt != 3'd0) begin
        // Walk p10 then p01 then p11
        case (cnt)
          3'd1:    o_src_raddr <= o_src_raddr + AW'(1);
          3'd2:    o_src_raddr <= o_src_raddr + AW'(i_cfg.in_w) - AW'(1);
          3'd3:    o_src_raddr <= o_src_raddr + AW'(1);
          default: o_src_raddr <= o_src_raddr;
        endcase
        if (cnt == 3'd5) begin
          cnt          <= 3'd0;
          o_quad_valid <= 1'b1;
        end else begin
          cnt <= cnt + 3'd1;
        end
      end
    end
  end

  // Samples arrive one step after their address
  always_ff @(posedge clk) begin
    if (i_fetch_start) begin
      o_pt <= pt_next;
    end
    case (cnt)
      3'd2:    o_quad.p00 <= i_src_rdata;
      3'd3:    o_quad.p10 <= i_src_rdata;
      3'd4:    o_quad.p01 <= i_src_rdata;
      3'd5:    o_quad.p11 <= i_src_rdata;
      default: o_quad <= o_quad;
    endcase
  end

endmodule

//--- verilog/raster_fsm.sv
`timescale 1ns/1ps

module raster_fsm #(
  parameter int AW = 19
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   i_start,
  input  scaler_pkg::scale_cfg_t i_cfg,
  input  logic                   i_pix_valid,
  input  scaler_pkg::pixel_t     i_pix,
  output logic                   o_busy,
  output logic                   o_done,
  output logic                   o_fetch_start,
  output scaler_pkg::dim_t       o_ox,
  output scaler_pkg::dim_t       o_oy,
  output logic [AW-1:0]          o_dst_waddr,
  output scaler_pkg::pixel_t     o_dst_wdata,
  output logic                   o_dst_we
);

  typedef enum logic [2:0] {
    IDLE,
    INIT,
    ROW_INIT,
    FETCH,
    WAIT_PIX,
    WRITE,
    DONE
  } state_t;

  state_t      state;
  logic        last_col;
  logic        last_row;
  logic [31:0] lin_addr;

  // End of row and end of frame
  assign last_col = (o_ox + 16'd1) >= i_cfg.out_w;
  assign last_row = (o_oy + 16'd1) >= i_cfg.out_h;

  // Raster address into the destination
  assign lin_addr = 32'(o_oy) * 32'(i_cfg.out_w) + 32'(o_ox);

  // One fetch request per pixel
  assign o_fetch_start = (state == FETCH);

  // ------------------------------
  // Control and raster counters
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= IDLE;
      o_busy   <= 1'b0;
      o_done   <= 1'b0;
      o_dst_we <= 1'b0;
      o_ox     <= '0;
      o_oy     <= '0;
    end else begin
      // Pulses by default
      o_done   <= 1'b0;
      o_dst_we <= 1'b0;
      case (state)
        IDLE: begin
          if (i_start) begin
            o_busy <= 1'b1;
            state  <= INIT;
          end
        end
        INIT: begin
          o_oy  <= '0;
          state <= ROW_INIT;
        end
        // Extra cycle paid on every new row
        ROW_INIT: begin
          o_ox  <= '0;
          state <= FETCH;
        end
        FETCH: begin
          state <= WAIT_PIX;
        end
        WAIT_PIX: begin
          if (i_pix_valid) begin
            o_dst_we <= 1'b1;
            state    <= WRITE;
          end
        end
        WRITE: begin
          if (last_col && last_row) begin
            // Busy drops together with done
            o_busy <= 1'b0;
            o_done <= 1'b1;
            state  <= DONE;
          end else if (last_col) begin
            o_oy  <= o_oy + 16'd1;
            state <= ROW_INIT;
          end else begin
            o_ox  <= o_ox + 16'd1;
            state <= FETCH;
          end
        end
        DONE: begin
          // Back-to-back frame allowed here
          if (i_start) begin
            o_busy <= 1'b1;
            state  <= INIT;
          end else begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Write payload captured with the pixel
  always_ff @(posedge clk) begin
    if (state == WAIT_PIX && i_pix_valid) begin
      o_dst_waddr <= lin_addr[AW-1:0];
      o_dst_wdata <= i_pix;
    end
  end

endmodule

//--- verilog/scale_setup.sv
`timescale 1ns/1ps

module scale_setup (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   i_start,
  input  scaler_pkg::dim_t       i_in_w,
  input  scaler_pkg::dim_t       i_in_h,
  input  scaler_pkg::q88_t       i_scale_q88,
  output scaler_pkg::scale_cfg_t o_cfg
);

  import scaler_pkg::*;

  // Size times scale lands in Q16.8
  logic [31:0] prod_w;
  logic [31:0] prod_h;
  // Inverse scale before truncation to Q8.8
  logic [31:0] inv_full;

  assign prod_w   = 32'(i_in_w) * 32'(i_scale_q88);
  assign prod_h   = 32'(i_in_h) * 32'(i_scale_q88);

  // Floor of 65536 / scale
  assign inv_full = INV_NUM / 32'(i_scale_q88);

  // ------------------------------
  // Configuration register
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_cfg <= '0;
    end else if (i_start) begin
      o_cfg.in_w      <= i_in_w;
      o_cfg.in_h      <= i_in_h;
      // Integer part of the Q16.8 product
      o_cfg.out_w     <= prod_w[23:8];
      o_cfg.out_h     <= prod_h[23:8];
      o_cfg.inv_scale <= inv_full[15:0];
    end
  end

endmodule

//--- verilog/scaler_pkg.sv
package scaler_pkg;

  // ------------------------------
  // Basic scalar types
  // ------------------------------

  // Image dimension or coordinate
  typedef logic [15:0] dim_t;
  // Q8.8 scale and inverse scale
  typedef logic [15:0] q88_t;
  // Q0.8 fractional part
  typedef logic [7:0]  frac_t;
  // Grey sample
  typedef logic [7:0]  pixel_t;

  // ------------------------------
  // Fixed-point constants
  // ------------------------------

  // 1.0 in Q0.8 needs the ninth bit
  localparam logic [8:0]  ONE_Q08    = 9'd256;
  // Half an LSB of the Q8.16 sum
  localparam logic [31:0] ROUND_Q016 = 32'h0000_8000;
  // 256 * 256 so the quotient lands in Q8.8
  localparam logic [31:0] INV_NUM    = 32'd65536;

  // ------------------------------
  // Bundles between blocks
  // ------------------------------

  // Frame configuration, 80 bits
  typedef struct packed {
    dim_t in_w;
    dim_t in_h;
    dim_t out_w;
    dim_t out_h;
    q88_t inv_scale;
  } scale_cfg_t;

  // Clamped source position, 48 bits
  typedef struct packed {
    dim_t  x0;
    dim_t  y0;
    frac_t fx;
    frac_t fy;
  } src_point_t;

  // Four neighbours around the source position
  typedef struct packed {
    pixel_t p00;
    pixel_t p10;
    pixel_t p01;
    pixel_t p11;
  } quad_pix_t;

endpackage
